// ==== src/upload_pkg.sv ====
package upload_pkg;

   localparam int HEADER_BYTES = 16;

   typedef logic [27:0] ddr_addr_t;   // Byte address in the image store
   typedef logic [26:0] ram_addr_t;
   typedef logic [24:0] data_size_t;
   typedef logic [3:0]  ref_ram_t;
   typedef logic [3:0]  slot_sel_t;   // Slot in 3:2, subslot in 1:0
   typedef logic [7:0]  mapper_t;

   localparam mapper_t MAPPER_UNUSED = 8'd0;

   typedef enum logic [7:0] {
      ID_NONE = 8'd0,
      ID_ROM  = 8'd1,
      ID_RAM  = 8'd2
   } data_id_t;

   typedef enum logic [3:0] {
      KIND_SLOT   = 4'd0,
      KIND_CONFIG = 4'd1
   } rec_kind_t;

   typedef struct packed {
      data_size_t size;
      logic [2:0] pattern;
      logic       from_stream;
   } fill_cmd_t;

   typedef struct packed {
      ram_addr_t   addr;
      logic [15:0] size;   // In blocks
      logic        ro;
   } ram_entry_t;

   typedef struct packed {
      mapper_t    mapper;
      ref_ram_t   ref_ram;
      logic [1:0] offset;
   } slot_entry_t;

   typedef struct packed {
      slot_sel_t  sel;
      mapper_t    mapper;
      logic [7:0] mode;    // Two bits per block
      logic [7:0] param;
      ref_ram_t   ref_ram;
      data_id_t   data_id;
   } slot_store_t;

   typedef struct packed {
      logic [3:0] slot_expander;
      logic [1:0] msx_type;
      logic [7:0] ram_size;
   } bios_cfg_t;

   typedef struct packed {
      ram_addr_t  addr;
      logic [7:0] data;
   } ram_wr_t;

endpackage

// ==== src/ddr_stream.sv ====
`timescale 1ns/1ps

module ddr_stream (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   scmd_valid,
   output logic                   scmd_ready,
   input  upload_pkg::ddr_addr_t  scmd_addr,
   input  upload_pkg::data_size_t scmd_len,
   output logic                   sbyte_valid,
   input  logic                   sbyte_ready,
   output logic [7:0]             sbyte,
   output logic                   mem_rd,
   output upload_pkg::ddr_addr_t  mem_addr,
   input  logic                   mem_ack,
   input  logic [7:0]             mem_dout
);

   upload_pkg::data_size_t remain;   // Bytes not yet acknowledged

   assign scmd_ready = remain == '0 && !mem_rd && !sbyte_valid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         remain      <= '0;
         mem_rd      <= 1'b0;
         sbyte_valid <= 1'b0;
      end else begin
         if (scmd_valid && scmd_ready) begin
            remain <= scmd_len;
            mem_rd <= scmd_len != '0;
         end
         if (mem_rd && mem_ack) begin
            mem_rd      <= 1'b0;
            remain      <= remain - 1'b1;
            sbyte_valid <= 1'b1;
         end
         if (sbyte_valid && sbyte_ready) begin
            sbyte_valid <= 1'b0;
            mem_rd      <= remain != '0;   // Next read only once the byte is gone
         end
      end
   end

   always_ff @(posedge clk) begin
      if (scmd_valid && scmd_ready) begin
         mem_addr <= scmd_addr;
      end
      if (mem_rd && mem_ack) begin
         mem_addr <= mem_addr + 1'b1;
         sbyte    <= mem_dout;
      end
   end

   a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mem_rd && !mem_ack |=> mem_rd && $stable(mem_addr));

endmodule

// ==== src/upload_sequencer.sv ====
`timescale 1ns/1ps

module upload_sequencer #(
   parameter int BLOCK_SHIFT = 14
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    download,
   input  upload_pkg::ddr_addr_t   image_size,
   output logic                    busy,
   output logic                    scmd_valid,
   input  logic                    scmd_ready,
   output upload_pkg::ddr_addr_t   scmd_addr,
   output upload_pkg::data_size_t  scmd_len,
   input  logic                    sbyte_valid,
   output logic                    sbyte_ready,
   input  logic [7:0]              sbyte,
   output logic                    fbyte_valid,
   input  logic                    fbyte_ready,
   output logic [7:0]              fbyte,
   output logic                    fill_valid,
   input  logic                    fill_ready,
   output upload_pkg::fill_cmd_t   fill,
   input  logic                    fill_done,
   input  upload_pkg::ref_ram_t    next_ref,
   output logic                    clear_start,
   input  logic                    clear_busy,
   output logic                    store_valid,
   output upload_pkg::slot_store_t store,
   output upload_pkg::bios_cfg_t   bios_cfg
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_CLEAN,
      S_READ_HEADER,
      S_CHECK,
      S_FILL,
      S_STORE
   } state_t;

   state_t                  state;
   logic                    download_q;
   logic                    start;
   upload_pkg::ddr_addr_t   img_size;
   upload_pkg::ddr_addr_t   hdr_addr;   // Next unread image byte
   logic [7:0]              hdr [upload_pkg::HEADER_BYTES];
   logic [3:0]              hdr_cnt;
   upload_pkg::ref_ram_t    ref_cap;
   upload_pkg::data_size_t  rec_size;
   upload_pkg::data_id_t    rec_id;
   upload_pkg::rec_kind_t   rec_kind;
   logic                    walk_done;
   logic                    magic_ok;
   logic                    hdr_take;

   assign start     = download_q && !download;
   assign busy      = state != S_IDLE;
   assign rec_size  = upload_pkg::data_size_t'({hdr[5][2:0], hdr[6]}) << BLOCK_SHIFT;
   assign rec_id    = upload_pkg::data_id_t'(hdr[4]);
   assign rec_kind  = upload_pkg::rec_kind_t'(hdr[3][7:4]);
   assign walk_done = hdr_addr >= img_size;
   assign magic_ok  = {hdr[0], hdr[1], hdr[2]} == "MSX";

   // Every command starts at the read pointer
   assign scmd_addr = hdr_addr;
   assign scmd_len  = state == S_FILL ? rec_size
                                      : upload_pkg::data_size_t'(upload_pkg::HEADER_BYTES);

   // Bytes left over from an aborted walk are dropped before the next header
   assign sbyte_ready = state == S_FILL ? fbyte_ready
                                        : state == S_CLEAN || state == S_READ_HEADER;
   assign hdr_take    = state == S_READ_HEADER && !scmd_valid && sbyte_valid;
   assign fbyte_valid = state == S_FILL && sbyte_valid;
   assign fbyte       = sbyte;

   assign fill.size        = rec_size;
   assign fill.from_stream = rec_id != upload_pkg::ID_RAM;
   assign fill.pattern     = fill.from_stream ? 3'd0 : hdr[11][2:0];

   assign store_valid   = state == S_STORE;
   assign store.sel     = hdr[3][3:0];
   assign store.mapper  = hdr[8];
   assign store.mode    = hdr[9];
   assign store.param   = hdr[10];
   assign store.ref_ram = rec_id == upload_pkg::ID_NONE ? '0 : ref_cap;
   assign store.data_id = rec_id;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= S_IDLE;
         download_q  <= 1'b0;
         clear_start <= 1'b0;
         scmd_valid  <= 1'b0;
         fill_valid  <= 1'b0;
         hdr_cnt     <= '0;
         hdr_addr    <= '0;
         img_size    <= '0;
         bios_cfg    <= '0;
      end else begin
         download_q  <= download;
         clear_start <= start;
         if (start) begin   // Also aborts a running walk
            state      <= S_CLEAN;
            scmd_valid <= 1'b0;
            fill_valid <= 1'b0;
            hdr_cnt    <= '0;
            hdr_addr   <= '0;
            img_size   <= image_size;
            bios_cfg   <= '0;
         end else begin
            if (scmd_valid && scmd_ready) begin
               scmd_valid <= 1'b0;
               hdr_addr   <= hdr_addr + upload_pkg::ddr_addr_t'(scmd_len);
            end
            if (fill_valid && fill_ready) begin
               fill_valid <= 1'b0;
            end
            case (state)
               S_CLEAN: begin
                  if (!clear_start && !clear_busy) begin
                     state      <= walk_done ? S_IDLE : S_READ_HEADER;
                     scmd_valid <= !walk_done;
                  end
               end
               S_READ_HEADER: begin
                  if (hdr_take) begin
                     hdr_cnt <= hdr_cnt + 1'b1;
                     if (hdr_cnt == 4'(upload_pkg::HEADER_BYTES - 1)) state <= S_CHECK;
                  end
               end
               S_CHECK: begin
                  if (!magic_ok) begin
                     state <= S_IDLE;
                  end else if (rec_kind == upload_pkg::KIND_SLOT) begin
                     if (rec_size != '0) begin
                        state      <= S_FILL;
                        fill_valid <= 1'b1;
                        scmd_valid <= fill.from_stream;   // ROM bytes follow the header
                        if (rec_id == upload_pkg::ID_RAM && hdr[6] > bios_cfg.ram_size) begin
                           bios_cfg.ram_size <= hdr[6];
                        end
                     end else begin
                        state <= S_STORE;
                     end
                  end else begin
                     if (rec_kind == upload_pkg::KIND_CONFIG) begin
                        bios_cfg.slot_expander <= hdr[4][3:0];
                        bios_cfg.msx_type      <= hdr[4][5:4];
                     end
                     state      <= walk_done ? S_IDLE : S_READ_HEADER;
                     scmd_valid <= !walk_done;
                  end
               end
               S_FILL: begin
                  if (fill_done) state <= S_STORE;
               end
               S_STORE: begin
                  state      <= walk_done ? S_IDLE : S_READ_HEADER;
                  scmd_valid <= !walk_done;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_take) begin
         hdr[hdr_cnt] <= sbyte;
      end
      if (state == S_CHECK) begin
         ref_cap <= next_ref;   // Entry the coming fill will use
      end
   end

endmodule

// ==== src/ram_loader.sv ====
`timescale 1ns/1ps

module ram_loader #(
   parameter int BLOCK_SHIFT = 14
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   restart,
   input  logic                   fill_valid,
   output logic                   fill_ready,
   input  upload_pkg::fill_cmd_t  fill,
   output logic                   fill_done,
   input  logic                   fbyte_valid,
   output logic                   fbyte_ready,
   input  logic [7:0]             fbyte,
   output upload_pkg::ref_ram_t   next_ref,
   output logic                   ram_wr_valid,
   output upload_pkg::ram_wr_t    ram_wr,
   input  logic                   ram_wr_ready,
   input  upload_pkg::ref_ram_t   lookup_sel,
   output upload_pkg::ram_entry_t lookup_entry
);

   upload_pkg::ram_entry_t lookup [16];
   upload_pkg::ram_addr_t  ram_addr;   // Next free RAM byte
   upload_pkg::data_size_t remain;
   upload_pkg::data_size_t pos;        // Offset inside the region
   logic [2:0]             pattern;
   logic                   active;
   logic                   use_stream;
   logic                   load;
   logic [7:0]             wr_byte;

   assign use_stream   = pattern == 3'd0;
   assign fill_ready   = !active;
   assign fbyte_ready  = active && use_stream && !ram_wr_valid;
   assign load         = active && !ram_wr_valid && (!use_stream || fbyte_valid);
   assign lookup_entry = lookup[lookup_sel];

   always_comb begin
      case (pattern)
         3'd0:    wr_byte = fbyte;
         3'd2:    wr_byte = 8'h00;
         3'd3:    wr_byte = pos[8] == !pos[1] ? 8'hff : 8'h00;
         3'd4:    wr_byte = pos[8] != pos[0] ? 8'hff : 8'h00;
         3'd5:    wr_byte = {8{pos[7]}};
         default: wr_byte = 8'hff;   // Pattern 1 and unknown codes
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n || restart) begin
         active       <= 1'b0;
         ram_wr_valid <= 1'b0;
         fill_done    <= 1'b0;
         ram_addr     <= '0;
         next_ref     <= '0;
         remain       <= '0;
         pos          <= '0;
         pattern      <= '0;
      end else begin
         fill_done <= 1'b0;
         if (fill_done) next_ref <= next_ref + 1'b1;
         if (fill_valid && fill_ready) begin
            active    <= fill.size != '0;
            fill_done <= fill.size == '0;
            remain    <= fill.size;
            pos       <= '0;
            pattern   <= fill.pattern;
         end
         if (load) ram_wr_valid <= 1'b1;
         if (ram_wr_valid && ram_wr_ready) begin
            ram_wr_valid <= 1'b0;
            ram_addr     <= ram_addr + 1'b1;   // Regions packed back to back
            pos          <= pos + 1'b1;
            remain       <= remain - 1'b1;
            if (remain == upload_pkg::data_size_t'(1)) begin
               active    <= 1'b0;
               fill_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_valid && fill_ready) begin
         lookup[next_ref].addr <= ram_addr;
         lookup[next_ref].size <= 16'(fill.size >> BLOCK_SHIFT);
         lookup[next_ref].ro   <= fill.from_stream;
      end
      if (load) begin
         ram_wr.addr <= ram_addr;
         ram_wr.data <= wr_byte;
      end
   end

endmodule

// ==== src/slot_table.sv ====
`timescale 1ns/1ps

module slot_table (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    clear_start,
   output logic                    clear_busy,
   input  logic                    store_valid,
   input  upload_pkg::slot_store_t store,
   input  logic [5:0]              layout_sel,
   output upload_pkg::slot_entry_t layout_entry
);

   upload_pkg::slot_entry_t layout [64];   // Index is {slot, subslot, block}
   logic [5:0]              clr_idx;

   assign layout_entry = layout[layout_sel];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         clear_busy <= 1'b0;
         clr_idx    <= '0;
      end else if (clear_start) begin
         clear_busy <= 1'b1;
         clr_idx    <= '0;
      end else if (clear_busy) begin
         clr_idx <= clr_idx + 1'b1;
         if (clr_idx == 6'd63) clear_busy <= 1'b0;
      end
   end

   // Mirror reads the entry as it was before this store
   always_ff @(posedge clk) begin
      if (clear_busy) begin
         layout[clr_idx] <= '{mapper: upload_pkg::MAPPER_UNUSED, ref_ram: '0, offset: '0};
      end else if (store_valid) begin
         for (int b = 0; b < 4; b++) begin
            case (store.mode[2*b +: 2])
               2'd1: layout[{store.sel, 2'(b)}] <= layout[{store.sel, store.param[2*b +: 2]}];
               2'd2: layout[{store.sel, 2'(b)}] <= '{mapper:  store.mapper,
                                                      ref_ram: store.ref_ram,
                                                      offset:  store.param[2*b +: 2]};
               2'd3: layout[{store.sel, 2'(b)}] <= '{mapper:  upload_pkg::MAPPER_UNUSED,
                                                      ref_ram: store.ref_ram,
                                                      offset:  store.param[2*b +: 2]};
               default: ;   // Keep
            endcase
         end
      end
   end

   a_no_store_in_clear: assert property (@(posedge clk) disable iff (!rst_n)
      clear_busy |-> !store_valid);

endmodule

// ==== src/upload_top.sv ====
`timescale 1ns/1ps

module upload_top #(
   parameter int BLOCK_SHIFT = 14
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    download,
   input  upload_pkg::ddr_addr_t   image_size,
   output logic                    busy,
   output logic                    mem_rd,
   output upload_pkg::ddr_addr_t   mem_addr,
   input  logic                    mem_ack,
   input  logic [7:0]              mem_dout,
   output logic                    ram_wr_valid,
   output upload_pkg::ram_wr_t     ram_wr,
   input  logic                    ram_wr_ready,
   output upload_pkg::bios_cfg_t   bios_cfg,
   input  upload_pkg::ref_ram_t    lookup_sel,
   output upload_pkg::ram_entry_t  lookup_entry,
   input  logic [5:0]              layout_sel,
   output upload_pkg::slot_entry_t layout_entry
);

   logic                    scmd_valid;
   logic                    scmd_ready;
   upload_pkg::ddr_addr_t   scmd_addr;
   upload_pkg::data_size_t  scmd_len;
   logic                    sbyte_valid;
   logic                    sbyte_ready;
   logic [7:0]              sbyte;
   logic                    fbyte_valid;
   logic                    fbyte_ready;
   logic [7:0]              fbyte;
   logic                    fill_valid;
   logic                    fill_ready;
   upload_pkg::fill_cmd_t   fill;
   logic                    fill_done;
   upload_pkg::ref_ram_t    next_ref;
   logic                    clear_start;
   logic                    clear_busy;
   logic                    store_valid;
   upload_pkg::slot_store_t store;

   ddr_stream u_stream (.*);

   upload_sequencer #(.BLOCK_SHIFT(BLOCK_SHIFT)) u_seq (.*);

   ram_loader #(.BLOCK_SHIFT(BLOCK_SHIFT)) u_loader (
      .restart (clear_start),   // A new walk starts RAM over
      .*
   );

   slot_table u_slots (.*);

endmodule

// ==== bench/upload_tb.sv ====
`timescale 1ns/1ps

module upload_tb;

   localparam int BLOCK_SHIFT  = 4;
   localparam int GOLDEN_WORDS = 512;
   localparam int LAYOUT_SIZE  = 64;

   logic                    clk;
   logic                    rst_n;
   logic                    download;
   upload_pkg::ddr_addr_t   image_size;
   logic                    busy;
   logic                    mem_rd;
   upload_pkg::ddr_addr_t   mem_addr;
   logic                    mem_ack;
   logic [7:0]              mem_dout;
   logic                    ram_wr_valid;
   upload_pkg::ram_wr_t     ram_wr;
   logic                    ram_wr_ready;
   upload_pkg::bios_cfg_t   bios_cfg;
   upload_pkg::ref_ram_t    lookup_sel;
   upload_pkg::ram_entry_t  lookup_entry;
   logic [5:0]              layout_sel;
   upload_pkg::slot_entry_t layout_entry;

   logic [47:0] golden [GOLDEN_WORDS];
   logic [7:0]  image [256];             // Store contents of the current case
   logic [47:0] exp_wr [$];              // Expected writes as {addr, data}
   int          seed = 32'hae43_7c4c;
   int          errors;
   int          checks;
   int          ptr;
   logic        timed_out;

   upload_top #(.BLOCK_SHIFT(BLOCK_SHIFT)) u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Store answers each read after 0 to 3 idle cycles
   initial begin
      int delay;
      mem_ack  = 1'b0;
      mem_dout = 8'h00;
      forever begin
         @(negedge clk);
         mem_ack = 1'b0;
         if (rst_n && mem_rd) begin
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk);
            checks++;
            assert (mem_addr < image_size) else begin
               $display("Read outside the image at address %h at time %0t", mem_addr, $time);
               errors++;
            end
            mem_ack  = 1'b1;
            mem_dout = image[mem_addr[7:0]];
         end
      end
   end

   // Random ready on the RAM write port
   initial begin
      ram_wr_ready = 1'b0;
      forever begin
         @(negedge clk);
         ram_wr_ready = ($random(seed) & 3) != 0;
         if (ram_wr_valid && ram_wr_ready) check_write();
      end
   end

   task automatic check_value(input string name, input logic [47:0] got,
                              input logic [47:0] exp);
      checks++;
      assert (got == exp) else begin
         $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_write();
      logic [47:0] exp;
      checks++;
      assert (exp_wr.size() > 0) else begin
         $display("Unexpected RAM write to address %h at time %0t", ram_wr.addr, $time);
         errors++;
      end
      if (exp_wr.size() > 0) begin
         exp = exp_wr.pop_front();
         checks++;
         assert (ram_wr == exp[34:0]) else begin
            $display("error at time %0t: ram_wr addr/data is %h/%h, expected %h/%h",
                     $time, ram_wr.addr, ram_wr.data, exp[34:8], exp[7:0]);
            errors++;
         end
      end
   endtask

   // One image from the golden words, walked and checked
   task automatic run_case();
      int size;
      int writes;
      int lookups;
      int lookup_base;
      int layout_base;
      int count;
      int limit;
      size = int'(golden[ptr]);
      ptr++;
      for (int i = 0; i < size; i++) begin
         image[i] = golden[ptr][7:0];
         ptr++;
      end
      writes = int'(golden[ptr]);
      ptr++;
      for (int i = 0; i < writes; i++) begin
         exp_wr.push_back(golden[ptr]);
         ptr++;
      end
      lookups     = int'(golden[ptr]);
      lookup_base = ptr + 1;
      layout_base = lookup_base + lookups;
      ptr         = layout_base + LAYOUT_SIZE + 1;   // bios_cfg word is the last one

      @(negedge clk);
      download   = 1'b1;
      image_size = upload_pkg::ddr_addr_t'(size);
      repeat (3) begin
         @(negedge clk);
         check_value("busy", 48'(busy), 48'd0);
         check_value("mem_rd", 48'(mem_rd), 48'd0);
         check_value("ram_wr_valid", 48'(ram_wr_valid), 48'd0);
      end
      download = 1'b0;
      @(negedge clk);
      check_value("busy", 48'(busy), 48'd1);

      limit = size * 8 + 200;
      count = 0;
      while (busy && count < limit) begin
         @(negedge clk);
         count++;
      end
      checks++;
      assert (!busy) else begin
         $display("Timeout, walk still running after %0d cycles", limit);
         errors++;
         timed_out = 1'b1;
      end
      if (!timed_out) begin
         checks++;
         assert (exp_wr.size() == 0) else begin
            $display("%0d expected RAM writes never arrived", exp_wr.size());
            errors++;
         end
         exp_wr.delete();
         for (int i = 0; i < lookups; i++) begin
            lookup_sel = upload_pkg::ref_ram_t'(i);
            @(negedge clk);
            check_value($sformatf("lookup_entry %0d", i), 48'(lookup_entry),
                        golden[lookup_base + i]);
         end
         for (int i = 0; i < LAYOUT_SIZE; i++) begin
            layout_sel = 6'(i);
            @(negedge clk);
            check_value($sformatf("layout_entry %0d", i), 48'(layout_entry),
                        golden[layout_base + i]);
         end
         check_value("bios_cfg", 48'(bios_cfg), golden[layout_base + LAYOUT_SIZE]);
      end
   endtask

   initial begin
      rst_n      = 1'b0;
      download   = 1'b0;
      image_size = '0;
      lookup_sel = '0;
      layout_sel = '0;
      errors     = 0;
      checks     = 0;
      ptr        = 0;
      timed_out  = 1'b0;
      $readmemh("bench/upload_golden.hex", golden);
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      run_case();                     // ROM, RAM patterns and config
      if (!timed_out) run_case();     // Bad magic in the third header
      $display("Checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== bench/upload_golden.hex ====
// Each case holds image size, image bytes, RAM write count and writes as {addr, data}
// then lookup count and entries as {addr, blocks, ro}, 64 layout entries and bios_cfg
// Case 1 image with a ROM record, RAM records for patterns 1 to 5 and a config record
80
4d 53 58 01 01 00 01 00 11 0a 04 00 00 00 00 00
10 21 32 43 54 65 76 87 98 a9 ba cb dc ed fe 0f
4d 53 58 02 02 00 01 00 22 aa e4 01 00 00 00 00
4d 53 58 01 02 00 01 00 33 53 42 02 00 00 00 00
4d 53 58 0e 02 00 01 00 44 02 03 03 00 00 00 00
4d 53 58 05 02 00 02 00 55 0b 01 04 00 00 00 00
4d 53 58 09 02 00 01 00 66 80 80 05 00 00 00 00
4d 53 58 10 2a 00 00 00 00 00 00 00 00 00 00 00
// RAM writes
70
0010 0121 0232 0343 0454 0565 0676 0787 0898 09a9 0aba 0bcb 0cdc 0ded 0efe 0f0f
10ff 11ff 12ff 13ff 14ff 15ff 16ff 17ff 18ff 19ff 1aff 1bff 1cff 1dff 1eff 1fff
2000 2100 2200 2300 2400 2500 2600 2700 2800 2900 2a00 2b00 2c00 2d00 2e00 2f00
3000 3100 32ff 33ff 3400 3500 36ff 37ff 3800 3900 3aff 3bff 3c00 3d00 3eff 3fff
4000 41ff 4200 43ff 4400 45ff 4600 47ff 4800 49ff 4a00 4bff 4c00 4dff 4e00 4fff
5000 51ff 5200 53ff 5400 55ff 5600 57ff 5800 59ff 5a00 5bff 5c00 5dff 5e00 5fff
6000 6100 6200 6300 6400 6500 6600 6700 6800 6900 6a00 6b00 6c00 6d00 6e00 6f00
// Lookup table
6
000003 200002 400002 600002 800004 c00002
// Layout table, slot 0 subslot 1 holds the mirror
0000 0000 0000 0000 000a 0441 0440 0441 0884 0885 0886 0887 0000 0000 0000 0000
0000 0000 0000 0000 0011 1550 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 1996 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 110f 0000 0000 0000 0000 0000 0000 0000
2a02
// Case 2 image, third header has bad magic so the fourth record is never reached
40
4d 53 58 03 00 00 00 00 77 02 01 00 00 00 00 00
4d 53 58 10 15 00 00 00 00 00 00 00 00 00 00 00
4d 53 59 02 02 00 01 00 88 aa e4 01 00 00 00 00
4d 53 58 04 02 00 01 00 99 aa e4 02 00 00 00 00
0
0
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1dc1 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
1500

// ==== sim.f ====
src/upload_pkg.sv
src/ddr_stream.sv
src/upload_sequencer.sv
src/ram_loader.sv
src/slot_table.sv
src/upload_top.sv
bench/upload_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the upload controller testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module upload_tb -f sim.f \
   && ./obj_dir/Vupload_tb | tee sim.log \
   || echo "Build or simulation run failed"
grep -qx "No errors" sim.log 2>/dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
